// File: command_top.f
+incdir+src
src/command_pkg.sv
src/handler_if.sv
src/command_sm.sv
src/loopback_sm.sv
src/rd_reg_sm.sv
src/wr_reg_sm.sv
src/register_bank.sv
src/tx_word_mux.sv
src/command_top.sv
tests/tb_command_top.sv

// File: tests/tb_command_top.sv
`timescale 1ns/1ps
`include "command_defines.svh"

module tb_command_top import command_pkg::*; ();

	logic                   clk;
	logic                   reset;
	data_word_t             rx_data;
	logic                   rx_tvalid;
	logic                   rx_tlast;
	logic                   rx_tready;
	data_word_t             tx_data;
	logic                   tx_tvalid;
	logic                   tx_tlast;
	logic                   tx_tready;
	logic [2:0]             ch_addr;
	logic [`CHAN_TAG_W-1:0] channel_tag;
	logic                   command_sm_idle;

	data_word_t             got[$];         // words of the last reply
	data_word_t             model_scratch;  // expected register 0
	logic [`CHAN_TAG_W-1:0] model_tag;      // expected register 1
	int                     errors;
	int                     passed;
	int                     failed;
	int                     test_start;     // error count when the test began

	command_top uut (.*);

	task automatic drive_clock();
		clk = 1'b0;
		forever #4 clk = ~clk;                  // 8 ns period
	endtask

	initial drive_clock();

	// six tests of at most 3000 cycles each
	initial begin
		#(6 * 3000 * 8);
		$display("watchdog expired, a reply or the return to idle never came");
		$display("Verification failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// stream driver and monitor
	task automatic send_frame(input data_word_t frame[$], input bit stall);
		int i;
		i = 0;
		while (i < frame.size()) begin
			if (stall && ($urandom_range(0, 3) == 0)) begin
				rx_tvalid <= 1'b0;              // receive gap
				@(posedge clk);
			end else begin
				rx_data   <= frame[i];
				rx_tvalid <= 1'b1;
				rx_tlast  <= (i == frame.size() - 1);
				@(posedge clk);
				if (rx_tready)                  // word taken on this edge
					i++;
			end
		end
		rx_tvalid <= 1'b0;
		rx_tlast  <= 1'b0;
	endtask

	task automatic collect_reply(input bit stall);
		bit         finished;
		bit         held;                       // word was on offer but not taken
		data_word_t held_word;
		finished = 1'b0;
		held     = 1'b0;
		got.delete();
		while (!finished) begin
			tx_tready <= stall ? ($urandom_range(0, 2) != 0) : 1'b1;
			@(posedge clk);
			if (held) begin
				assert (tx_tvalid) else begin
					$display("tx_tvalid dropped before the word was taken");
					errors++;
				end
				assert (tx_data === held_word) else begin
					$display("** Error tx_data = %h under back-pressure, held %h", tx_data, held_word);
					errors++;
				end
			end
			held      = tx_tvalid && !tx_tready;
			held_word = tx_data;
			if (tx_tvalid && tx_tready) begin
				got.push_back(tx_data);
				finished = tx_tlast;            // reply ends on tx_tlast
			end
		end
		tx_tready <= 1'b0;
	endtask

	task automatic run_frame(input data_word_t frame[$], input bit stall);
		fork
			send_frame(frame, stall);
			collect_reply(stall);
		join
		assert (!command_sm_idle) else begin
			$display("command_sm_idle was high before the reply ended");
			errors++;
		end
		while (!command_sm_idle)                // frames never overlap
			@(posedge clk);
	endtask

	task automatic compare_reply(input string name, input data_word_t exp[$]);
		assert (got.size() == exp.size()) else begin
			$display("%s: reply had %0d words, expected %0d", name, got.size(), exp.size());
			errors++;
		end
		for (int i = 0; i < got.size() && i < exp.size(); i++) begin
			assert (got[i] === exp[i]) else begin
				$display("** Error %s: tx_data word %0d = %h, expected %h", name, i, got[i], exp[i]);
				errors++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// one frame per command with its expected reply
	task automatic loopback_frame(input string name, input int n, input bit stall);
		data_word_t frame[$];
		data_word_t cmd;
		cmd = $urandom;
		cmd[`CMD_CODE_W-1:0] = `CC_LOOPBACK;     // upper bits just ride along
		frame.push_back($urandom);
		frame.push_back(cmd);
		for (int i = 0; i < n; i++)
			frame.push_back($urandom);
		run_frame(frame, stall);
		compare_reply(name, frame);             // echo is the frame itself
	endtask

	task automatic read_reg(input string name, input data_word_t num, input data_word_t value,
		input bit stall);
		data_word_t frame[$];
		data_word_t exp[$];
		data_word_t cmd;
		cmd = $urandom;
		cmd[`CMD_CODE_W-1:0] = `CC_RD_REG;
		frame.push_back($urandom);
		frame.push_back(cmd);
		frame.push_back(num);
		exp.push_back(frame[0]);
		if (num > 3) begin
			exp.push_back(~cmd);                // illegal number gets the inverse command only
		end else begin
			exp.push_back(cmd);
			exp.push_back(value);
		end
		run_frame(frame, stall);
		compare_reply(name, exp);
	endtask

	task automatic write_reg(input string name, input data_word_t num, input data_word_t value,
		input bit stall);
		data_word_t frame[$];
		data_word_t exp[$];
		data_word_t cmd;
		cmd = $urandom;
		cmd[`CMD_CODE_W-1:0] = `CC_WR_REG;
		frame.push_back($urandom);
		frame.push_back(cmd);
		frame.push_back(num);
		frame.push_back(value);
		exp.push_back(frame[0]);
		exp.push_back((num > 3) ? ~cmd : cmd);
		if (num == 0)
			model_scratch = value;
		if (num == 1)
			model_tag = value[`CHAN_TAG_W-1:0];  // 2 and 3 are read only
		run_frame(frame, stall);
		compare_reply(name, exp);
	endtask

	task automatic write_read_regs(input string name, input bit stall);
		data_word_t v0;
		data_word_t v1;
		v0 = $urandom;
		v1 = $urandom;
		write_reg(name, 0, v0, stall);
		write_reg(name, 1, v1, stall);
		read_reg(name, 0, model_scratch, stall);
		read_reg(name, 1, data_word_t'(model_tag), stall);
		assert (channel_tag === v1[`CHAN_TAG_W-1:0]) else begin
			$display("** Error channel_tag = %h, expected %h", channel_tag, v1[`CHAN_TAG_W-1:0]);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == test_start) begin
			$display("test %s: ok", name);
			passed++;
		end else begin
			$display("test %s: %0d checks failed", name, errors - test_start);
			failed++;
		end
		test_start = errors;
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	task automatic test_read_only();
		ch_addr <= 3'd6;
		read_reg("read-only", 2, 3, 0);         // jumper 6 reads as 3
		ch_addr <= 3'd5;
		read_reg("read-only", 2, 5, 0);
		read_reg("read-only", 3, `FW_VERSION, 0);
		write_reg("read-only", 3, $urandom, 0);
		read_reg("read-only", 3, `FW_VERSION, 0);
		end_test("read-only");
	endtask

	task automatic test_illegal();
		read_reg("illegal", 7, '0, 0);
		write_reg("illegal", 7, $urandom, 0);
		write_reg("illegal", 4, $urandom, 0);   // low bits select register 0, must not touch it
		read_reg("illegal", 0, model_scratch, 0);
		end_test("illegal");
	endtask

	task automatic test_unknown();
		data_word_t frame[$];
		data_word_t cmd;
		bit         sent;
		int         stray;                      // reply words seen during the frame
		cmd = $urandom;
		cmd[`CMD_CODE_W-1:0] = 5'd9;
		frame.push_back($urandom);
		frame.push_back(cmd);
		repeat (3) frame.push_back($urandom);
		sent  = 1'b0;
		stray = 0;
		tx_tready <= 1'b1;
		fork
			begin
				send_frame(frame, 1'b0);
				sent = 1'b1;
			end
			while (!(sent && command_sm_idle)) begin
				@(posedge clk);
				if (tx_tvalid)
					stray++;
			end
		join
		tx_tready <= 1'b0;
		assert (stray == 0) else begin
			$display("unknown code frame produced %0d reply words", stray);
			errors++;
		end
		loopback_frame("unknown code", 2, 0);   // next frame must still be served
		end_test("unknown code");
	endtask

	initial begin
		void'($urandom(83048));
		rx_data       = '0;
		rx_tvalid     = 1'b0;
		rx_tlast      = 1'b0;
		tx_tready     = 1'b0;
		ch_addr       = 3'd5;
		reset         = 1'b1;
		model_scratch = '0;                     // bank resets to zero
		model_tag     = '0;
		errors        = 0;
		passed        = 0;
		failed        = 0;
		test_start    = 0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		loopback_frame("loopback", $urandom_range(1, 6), 0);
		end_test("loopback");
		write_read_regs("write then read", 0);
		end_test("write then read");
		test_read_only();
		test_illegal();
		loopback_frame("back-pressure", $urandom_range(1, 6), 1);
		write_read_regs("back-pressure", 1);
		end_test("back-pressure");
		test_unknown();

		$display("tests passed %0d, failed %0d, checks failed %0d", passed, failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: src/command_top.sv
`timescale 1ns/1ps
`include "command_defines.svh"

module command_top (
	input  logic                    clk,
	input  logic                    reset,
	// receive stream
	input  command_pkg::data_word_t rx_data,
	input  logic                    rx_tvalid,
	input  logic                    rx_tlast,
	output logic                    rx_tready,
	// transmit stream
	output command_pkg::data_word_t tx_data,
	output logic                    tx_tvalid,
	output logic                    tx_tlast,
	input  logic                    tx_tready,
	// board side
	input  logic [2:0]              ch_addr,          // channel address jumpers
	output logic [`CHAN_TAG_W-1:0]  channel_tag,      // register 1 contents
	output logic                    command_sm_idle   // front panel status
);

	command_pkg::data_word_t serial_num;
	command_pkg::data_word_t command;
	command_pkg::data_word_t reg_data;
	logic cmd_rx_tready;
	logic rd_reg_num_le;
	logic wr_reg_num_le;
	logic rd_en;
	logic wr_en;
	logic illegal_reg_num;

	handler_if lb_if ();   // loopback
	handler_if rd_if ();   // register read
	handler_if wr_if ();   // register write

	// whoever owns the receive stream drives ready
	assign rx_tready = cmd_rx_tready || lb_if.rx_tready || rd_if.rx_tready || wr_if.rx_tready;

	////////////////////////////////////////////////////////////
	command_sm u_command_sm (
		.clk(clk), .reset(reset),
		.rx_data(rx_data), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tready(cmd_rx_tready),
		.serial_num(serial_num), .command(command),
		.lb(lb_if.dispatch), .rd(rd_if.dispatch), .wr(wr_if.dispatch),
		.sm_idle(command_sm_idle)
	);

	loopback_sm u_loopback_sm (
		.clk(clk), .reset(reset),
		.rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .tx_tready(tx_tready),
		.hif(lb_if.handler)
	);

	rd_reg_sm u_rd_reg_sm (
		.clk(clk), .reset(reset),
		.rx_tvalid(rx_tvalid), .tx_tready(tx_tready),
		.reg_num_le(rd_reg_num_le), .rd_en(rd_en), .illegal_reg_num(illegal_reg_num),
		.hif(rd_if.handler)
	);

	wr_reg_sm u_wr_reg_sm (
		.clk(clk), .reset(reset),
		.rx_tvalid(rx_tvalid), .tx_tready(tx_tready),
		.reg_num_le(wr_reg_num_le), .wr_en(wr_en), .illegal_reg_num(illegal_reg_num),
		.hif(wr_if.handler)
	);

	////////////////////////////////////////////////////////////
	register_bank u_register_bank (
		.clk(clk), .reset(reset),
		.rx_data(rx_data),
		.reg_num_le(rd_reg_num_le || wr_reg_num_le),  // either handler latches the number
		.rd_en(rd_en), .wr_en(wr_en),
		.ch_addr(ch_addr),
		.illegal_reg_num(illegal_reg_num), .reg_data(reg_data), .channel_tag(channel_tag)
	);

	tx_word_mux u_tx_word_mux (
		.clk(clk), .reset(reset),
		.lb(lb_if.tx), .rd(rd_if.tx), .wr(wr_if.tx),
		.serial_num(serial_num), .command(command), .rx_data(rx_data), .reg_data(reg_data),
		.tx_data(tx_data), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast)
	);

endmodule

// File: src/tx_word_mux.sv
`timescale 1ns/1ps

module tx_word_mux import command_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	handler_if.tx      lb,           // loopback handler requests
	handler_if.tx      rd,           // register read handler requests
	handler_if.tx      wr,           // register write handler requests
	input  data_word_t serial_num,
	input  data_word_t command,
	input  data_word_t rx_data,
	input  data_word_t reg_data,
	output data_word_t tx_data,      // registered outgoing word
	output logic       tx_tvalid,
	output logic       tx_tlast
);

	logic    load;
	tx_src_t src;

	assign load = lb.tx_load || rd.tx_load || wr.tx_load;

	// only one handler runs, order is arbitrary
	always_comb begin
		if (lb.tx_load)
			src = lb.tx_src;
		else if (rd.tx_load)
			src = rd.tx_src;
		else
			src = wr.tx_src;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_data <= '0;
		end else if (load) begin
			case (src)
				SRC_SERIAL:   tx_data <= serial_num;
				SRC_CMD:      tx_data <= command;
				SRC_INV_CMD:  tx_data <= ~command;    // illegal register reply
				SRC_RX_DATA:  tx_data <= rx_data;
				SRC_REG_DATA: tx_data <= reg_data;
				default:      tx_data <= tx_data;
			endcase
		end
	end

	assign tx_tvalid = lb.tx_tvalid || rd.tx_tvalid || wr.tx_tvalid;
	assign tx_tlast  = lb.tx_tlast || rd.tx_tlast || wr.tx_tlast;

endmodule

// File: src/register_bank.sv
`timescale 1ns/1ps
`include "command_defines.svh"

module register_bank import command_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  data_word_t             rx_data,          // register number or write data
	input  logic                   reg_num_le,       // latch the register number
	input  logic                   rd_en,            // load the read data register
	input  logic                   wr_en,            // write rx_data
	input  logic [2:0]             ch_addr,          // channel address jumpers
	output logic                   illegal_reg_num,
	output data_word_t             reg_data,         // read data register
	output logic [`CHAN_TAG_W-1:0] channel_tag
);

	data_word_t             reg_num_q;    // whole word kept for the range check
	reg_num_t               sel;
	data_word_t             scratch;
	logic [`CHAN_TAG_W-1:0] chan_tag;
	logic [2:0]             ch_addr_q;    // corrected jumper value

	assign sel             = reg_num_q[`REG_NUM_W-1:0];
	assign illegal_reg_num = |reg_num_q[`CMD_DATA_W-1:`REG_NUM_W];  // any upper bit set
	assign channel_tag     = chan_tag;

	////////////////////////////////////////////////////////////
	// register number and writable registers
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_num_q <= '0;
			scratch   <= '0;
			chan_tag  <= '0;
		end else begin
			if (reg_num_le)
				reg_num_q <= rx_data;
			if (wr_en && !illegal_reg_num) begin
				case (sel)
					`REG_SCRATCH:  scratch  <= rx_data;
					`REG_CHAN_TAG: chan_tag <= rx_data[`CHAN_TAG_W-1:0];
					default:       ;                // read-only, write accepted and dropped
				endcase
			end
		end
	end

	// channel 3 board has its jumpers set to 110 instead of 011
	always_ff @(posedge clk) begin
		ch_addr_q <= (ch_addr == 3'b110) ? 3'b011 : ch_addr;
	end

	////////////////////////////////////////////////////////////
	// read data register, valid the cycle after rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			case (sel)
				`REG_SCRATCH:  reg_data <= scratch;
				`REG_CHAN_TAG: reg_data <= {{(`CMD_DATA_W-`CHAN_TAG_W){1'b0}}, chan_tag};
				`REG_CH_ADDR:  reg_data <= {{(`CMD_DATA_W-3){1'b0}}, ch_addr_q};
				default:       reg_data <= `FW_VERSION;       // REG_VERSION
			endcase
		end
	end

endmodule

// File: src/wr_reg_sm.sv
`timescale 1ns/1ps

module wr_reg_sm import command_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx_tvalid,
	input  logic       tx_tready,
	output logic       reg_num_le,       // latch register number from rx_data
	output logic       wr_en,            // write rx_data into the bank
	input  logic       illegal_reg_num,  // latched number is out of range
	handler_if.handler hif
);

	localparam logic [2:0] S_IDLE    = 3'd0;
	localparam logic [2:0] S_RX_NUM  = 3'd1;   // register number word
	localparam logic [2:0] S_RX_DAT  = 3'd2;   // data word, written on transfer
	localparam logic [2:0] S_LD_SER  = 3'd3;
	localparam logic [2:0] S_TX_SER  = 3'd4;
	localparam logic [2:0] S_LD_ACK  = 3'd5;   // command or its inverse
	localparam logic [2:0] S_TX_LAST = 3'd6;
	localparam logic [2:0] S_DONE    = 3'd7;

	logic [2:0] state;

	assign hif.rx_tready = (state == S_RX_NUM) || (state == S_RX_DAT);
	assign reg_num_le    = rx_tvalid && (state == S_RX_NUM);
	assign wr_en         = rx_tvalid && (state == S_RX_DAT);  // bank drops illegal writes
	assign hif.tx_load   = (state == S_LD_SER) || (state == S_LD_ACK);
	assign hif.tx_tvalid = (state == S_TX_SER) || (state == S_TX_LAST);
	assign hif.tx_tlast  = (state == S_TX_LAST);
	assign hif.done      = (state == S_DONE);

	always_comb begin
		case (state)
			S_LD_SER: hif.tx_src = SRC_SERIAL;
			S_LD_ACK: hif.tx_src = illegal_reg_num ? SRC_INV_CMD : SRC_CMD;
			default:  hif.tx_src = SRC_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:    if (hif.run) state <= S_RX_NUM;
				S_RX_NUM:  if (rx_tvalid) state <= S_RX_DAT;
				S_RX_DAT:  if (rx_tvalid) state <= S_LD_SER;
				S_LD_SER:  state <= S_TX_SER;
				S_TX_SER:  if (tx_tready) state <= S_LD_ACK;
				S_LD_ACK:  state <= S_TX_LAST;
				S_TX_LAST: if (tx_tready) state <= S_DONE;
				default:   state <= S_IDLE;                   // S_DONE
			endcase
		end
	end

endmodule

// File: src/rd_reg_sm.sv
`timescale 1ns/1ps

module rd_reg_sm import command_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx_tvalid,
	input  logic       tx_tready,
	output logic       reg_num_le,       // latch register number from rx_data
	output logic       rd_en,            // load bank read data register
	input  logic       illegal_reg_num,  // latched number is out of range
	handler_if.handler hif
);

	localparam logic [3:0] S_IDLE    = 4'd0;
	localparam logic [3:0] S_RX_NUM  = 4'd1;   // register number word
	localparam logic [3:0] S_LD_SER  = 4'd2;
	localparam logic [3:0] S_TX_SER  = 4'd3;
	localparam logic [3:0] S_LD_CMD  = 4'd4;
	localparam logic [3:0] S_TX_CMD  = 4'd5;
	localparam logic [3:0] S_RD      = 4'd6;   // bank read, data ready next cycle
	localparam logic [3:0] S_LD_REG  = 4'd7;
	localparam logic [3:0] S_LD_INV  = 4'd8;   // illegal number reply
	localparam logic [3:0] S_TX_LAST = 4'd9;
	localparam logic [3:0] S_DONE    = 4'd10;

	logic [3:0] state;

	assign hif.rx_tready = (state == S_RX_NUM);
	assign reg_num_le    = rx_tvalid && hif.rx_tready;
	assign rd_en         = (state == S_RD);
	assign hif.tx_load   = (state == S_LD_SER) || (state == S_LD_CMD) ||
		(state == S_LD_REG) || (state == S_LD_INV);
	assign hif.tx_tvalid = (state == S_TX_SER) || (state == S_TX_CMD) || (state == S_TX_LAST);
	assign hif.tx_tlast  = (state == S_TX_LAST);
	assign hif.done      = (state == S_DONE);

	always_comb begin
		case (state)
			S_LD_SER: hif.tx_src = SRC_SERIAL;
			S_LD_CMD: hif.tx_src = SRC_CMD;
			S_LD_REG: hif.tx_src = SRC_REG_DATA;
			S_LD_INV: hif.tx_src = SRC_INV_CMD;
			default:  hif.tx_src = SRC_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:    if (hif.run) state <= S_RX_NUM;
				S_RX_NUM:  if (rx_tvalid) state <= S_LD_SER;
				S_LD_SER:  state <= S_TX_SER;
				// number is latched by now, pick the reply
				S_TX_SER:  if (tx_tready) state <= illegal_reg_num ? S_LD_INV : S_LD_CMD;
				S_LD_CMD:  state <= S_TX_CMD;
				S_TX_CMD:  if (tx_tready) state <= S_RD;
				S_RD:      state <= S_LD_REG;
				S_LD_REG:  state <= S_TX_LAST;
				S_LD_INV:  state <= S_TX_LAST;
				S_TX_LAST: if (tx_tready) state <= S_DONE;
				default:   state <= S_IDLE;                   // S_DONE
			endcase
		end
	end

endmodule

// File: src/loopback_sm.sv
`timescale 1ns/1ps

module loopback_sm import command_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx_tvalid,
	input  logic       rx_tlast,    // end of payload
	input  logic       tx_tready,
	handler_if.handler hif
);

	localparam logic [2:0] S_IDLE   = 3'd0;
	localparam logic [2:0] S_LD_SER = 3'd1;  // load serial number
	localparam logic [2:0] S_TX_SER = 3'd2;
	localparam logic [2:0] S_LD_CMD = 3'd3;  // load command word
	localparam logic [2:0] S_TX_CMD = 3'd4;
	localparam logic [2:0] S_RX     = 3'd5;  // take one payload word, load it
	localparam logic [2:0] S_TX_DAT = 3'd6;
	localparam logic [2:0] S_DONE   = 3'd7;

	logic [2:0] state;
	logic       last_q;   // loaded payload word carried rx_tlast
	logic       rx_xfer;

	assign hif.rx_tready = (state == S_RX);
	assign rx_xfer       = rx_tvalid && hif.rx_tready;
	assign hif.tx_load   = (state == S_LD_SER) || (state == S_LD_CMD) || rx_xfer;
	assign hif.tx_tvalid = (state == S_TX_SER) || (state == S_TX_CMD) || (state == S_TX_DAT);
	assign hif.tx_tlast  = (state == S_TX_DAT) && last_q;
	assign hif.done      = (state == S_DONE);

	always_comb begin
		case (state)
			S_LD_SER: hif.tx_src = SRC_SERIAL;
			S_LD_CMD: hif.tx_src = SRC_CMD;
			S_RX:     hif.tx_src = SRC_RX_DATA;  // word goes straight into the mux register
			default:  hif.tx_src = SRC_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:   if (hif.run) state <= S_LD_SER;
				S_LD_SER: state <= S_TX_SER;
				S_TX_SER: if (tx_tready) state <= S_LD_CMD;
				S_LD_CMD: state <= S_TX_CMD;
				S_TX_CMD: if (tx_tready) state <= S_RX;
				S_RX:     if (rx_tvalid) state <= S_TX_DAT;   // stalls on a receive gap
				S_TX_DAT: if (tx_tready) state <= last_q ? S_DONE : S_RX;
				default:  state <= S_IDLE;                    // S_DONE
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx_xfer)
			last_q <= rx_tlast;
	end

endmodule

// File: src/command_sm.sv
`timescale 1ns/1ps
`include "command_defines.svh"

module command_sm import command_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  data_word_t  rx_data,      // receive stream
	input  logic        rx_tvalid,
	input  logic        rx_tlast,
	output logic        rx_tready,    // registered, low out of reset
	output data_word_t  serial_num,   // latched frame serial number
	output data_word_t  command,      // latched command word
	handler_if.dispatch lb,           // loopback handler
	handler_if.dispatch rd,           // register read handler
	handler_if.dispatch wr,           // register write handler
	output logic        sm_idle       // waiting for a new frame
);

	localparam logic [2:0] S_SERIAL = 3'd0;  // idle, next word is the serial number
	localparam logic [2:0] S_CMD    = 3'd1;  // next word is the command
	localparam logic [2:0] S_RUN    = 3'd2;  // start one handler
	localparam logic [2:0] S_WAIT   = 3'd3;  // handler owns the streams
	localparam logic [2:0] S_DRAIN  = 3'd4;  // unknown code, swallow the rest

	logic [2:0] state;
	logic [2:0] state_next;
	cmd_code_t  code;
	logic       rx_xfer;
	logic       known;
	logic       any_done;

	assign rx_xfer  = rx_tvalid && rx_tready;
	assign code     = command[`CMD_CODE_W-1:0];    // upper command bits only echoed
	assign known    = (code == `CC_LOOPBACK) || (code == `CC_RD_REG) || (code == `CC_WR_REG);
	assign any_done = lb.done || rd.done || wr.done; // one handler active at a time
	assign sm_idle  = (state == S_SERIAL);

	// one-cycle start pulses, cycle after the command word
	assign lb.run = (state == S_RUN) && (code == `CC_LOOPBACK);
	assign rd.run = (state == S_RUN) && (code == `CC_RD_REG);
	assign wr.run = (state == S_RUN) && (code == `CC_WR_REG);

	always_comb begin
		state_next = state;
		case (state)
			S_SERIAL: if (rx_xfer) state_next = S_CMD;
			S_CMD:    if (rx_xfer) state_next = S_RUN;
			S_RUN:    state_next = known ? S_WAIT : S_DRAIN;  // no reply for unknown codes
			S_WAIT:   if (any_done) state_next = S_SERIAL;
			S_DRAIN:  if (rx_xfer && rx_tlast) state_next = S_SERIAL;
			default:  state_next = S_SERIAL;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= S_SERIAL;
			rx_tready <= 1'b0;
		end else begin
			state     <= state_next;
			// ready follows the state we are about to enter
			rx_tready <= (state_next == S_SERIAL) || (state_next == S_CMD) ||
				(state_next == S_DRAIN);
		end
	end

	// frame header words, held for the reply
	always_ff @(posedge clk) begin
		if (rx_xfer && (state == S_SERIAL))
			serial_num <= rx_data;
		if (rx_xfer && (state == S_CMD))
			command <= rx_data;
	end

endmodule

// File: src/handler_if.sv
`timescale 1ns/1ps

interface handler_if;

	logic                 run;        // start pulse from the dispatcher
	logic                 done;       // finished pulse from the handler
	logic                 rx_tready;  // handler is taking receive words
	logic                 tx_load;    // load the transmit word this cycle
	command_pkg::tx_src_t tx_src;     // source of the word being loaded
	logic                 tx_tvalid;  // loaded word is on offer
	logic                 tx_tlast;   // loaded word ends the reply

	// dispatcher side
	modport dispatch (
		output run,
		input  done
	);

	// command handler side
	modport handler (
		input  run,
		output done, rx_tready, tx_load, tx_src, tx_tvalid, tx_tlast
	);

	// transmit word mux
	modport tx (
		input  tx_load, tx_src, tx_tvalid, tx_tlast
	);

endinterface

// File: src/command_pkg.sv
`include "command_defines.svh"

package command_pkg;

	typedef logic [`CMD_DATA_W-1:0] data_word_t;  // one stream word
	typedef logic [`CMD_CODE_W-1:0] cmd_code_t;   // command code field
	typedef logic [`REG_NUM_W-1:0]  reg_num_t;    // register index

	// where the next outgoing word comes from
	typedef enum logic [2:0] {
		SRC_NONE,                                 // hold the current word
		SRC_SERIAL,                               // frame serial number
		SRC_CMD,                                  // command word, success
		SRC_INV_CMD,                              // inverted command, illegal register
		SRC_RX_DATA,                              // receive stream word, loopback
		SRC_REG_DATA                              // register bank read data
	} tx_src_t;

endpackage

// File: src/command_defines.svh
`ifndef COMMAND_DEFINES_SVH
`define COMMAND_DEFINES_SVH

////////////////////////////////////////////////////////////
// stream and command word layout
`define CMD_DATA_W   32               // receive and transmit stream width
`define CMD_CODE_W   5                // command code, low bits of the command word

// command codes
`define CC_LOOPBACK  5'd1             // echo the payload
`define CC_RD_REG    5'd2             // read one register
`define CC_WR_REG    5'd3             // write one register

////////////////////////////////////////////////////////////
// register map
`define REG_NUM_W    2                // legal numbers fit here, upper bits must be zero
`define REG_SCRATCH  2'd0             // read/write scratch word
`define REG_CHAN_TAG 2'd1             // read/write, also drives the channel_tag port
`define REG_CH_ADDR  2'd2             // corrected jumper value, read only
`define REG_VERSION  2'd3             // firmware version, read only

`define FW_VERSION   32'h0301_0004    // value returned by register 3
`define CHAN_TAG_W   12               // channel tag width

`endif
